// File: hdl/lar_isa_pkg.sv
package lar_isa_pkg;

	// opcodes, a zero word decodes as a no-op
	typedef enum logic [3:0]
	{
		op_ldw  = 4'h1,
		op_stw  = 4'h2,
		op_seta = 4'h3,
		op_add  = 4'h4,
		op_sub  = 4'h5,
		op_halt = 4'hf
	} opcode_t;

	// integer lane size of a LAR, code 3 behaves as sz32
	typedef enum logic [1:0]
	{
		sz8  = 2'd0,
		sz16 = 2'd1,
		sz32 = 2'd2
	} lane_size_t;

	// instruction word, msb first
	typedef struct packed
	{
		opcode_t opcode;
		logic [1:0] ra;
		logic [1:0] rb;
		logic [1:0] rc;
		lane_size_t size;
		logic [3:0] unused;
		logic [15:0] imm;
	} instr_t;

	// metadata carried by each LAR
	typedef struct packed
	{
		logic [15:0] addr;
		lane_size_t size;
	} lar_meta_t;

	// one LAR read port
	typedef struct packed
	{
		lar_meta_t meta;
		logic [31:0] data;
	} lar_rd_t;

	// LAR write port
	typedef struct packed
	{
		logic en;
		logic [1:0] idx;
		lar_meta_t meta;
		logic [31:0] data;
	} lar_wr_t;

	// word address of the first fetch
	localparam logic [15:0] reset_pc = 16'h0000;

endpackage

// File: hdl/lar_bus_pkg.sv
package lar_bus_pkg;

	// guard to memory, word addressed
	typedef struct packed
	{
		logic req;
		logic we;
		logic [15:0] addr;
		logic [31:0] wdata;
	} bus_req_t;

	// memory to guard
	typedef struct packed
	{
		logic ack;
		logic [31:0] rdata;
	} bus_rsp_t;

	// controller to guard, start is a single cycle pulse
	typedef struct packed
	{
		logic start;
		logic we;
		logic [15:0] addr;
		logic [31:0] wdata;
	} mem_access_t;

	// guard to controller
	// rdata held until the next start
	typedef struct packed
	{
		logic done;
		logic [31:0] rdata;
	} mem_result_t;

endpackage

// File: hdl/lar_file.sv
`timescale 1ns/1ps

module lar_file
	import lar_isa_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic [1:0] rd_idx_a,
	input logic [1:0] rd_idx_b,
	input logic [1:0] rd_idx_c,
	input lar_wr_t wr,
	output lar_rd_t rd_a,
	output lar_rd_t rd_b,
	output lar_rd_t rd_c
);

	// four LARs, metadata and data side by side
	lar_rd_t lars [4];

	// single write port
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			// address 0, widest lanes, zero data
			for (int i = 0; i < 4; i++)
			begin
				lars[i] <= '{meta: '{addr: 16'd0, size: sz32}, data: 32'd0};
			end
		end
		else if (wr.en)
		begin
			lars[wr.idx] <= '{meta: wr.meta, data: wr.data};
		end
	end

	// combinational reads
	// a write is visible only after the edge
	assign rd_a = lars[rd_idx_a];
	assign rd_b = lars[rd_idx_b];
	assign rd_c = lars[rd_idx_c];

	// controller folds size code 3 into sz32 before writing
	for (genvar k = 0; k < 4; k++)
	begin : g_size_chk
		a_size_legal: assert property (
			@(posedge clk) disable iff (!arst_n)
			(wr.en && (wr.idx == 2'(k))) |=> (lars[k].meta.size != 2'd3)
		)
		else
			$error("lar %0d holds lane size code 3", k);
	end

endmodule

// File: hdl/lane_alu.sv
`timescale 1ns/1ps

module lane_alu
	import lar_isa_pkg::*;
(
	input logic [31:0] a,
	input logic [31:0] b,
	input lane_size_t size,
	input logic sub,
	output logic [31:0] y
);

	// one byte slice at a time, carry stops at lane edges
	logic [31:0] b_eff;
	logic carry;
	logic [8:0] sum;

	// true when byte idx opens a new lane
	function automatic logic lane_start(input int idx, input lane_size_t sz);
		case (sz)
			sz8:
				return 1'b1;
			sz16:
				return (idx % 2) == 0;
			default:
				return idx == 0;
		endcase
	endfunction

	always_comb
	begin
		// subtract is a + ~b + 1 inside each lane
		b_eff = sub ? ~b : b;
		carry = sub;
		sum = 9'd0;
		y = 32'd0;
		for (int i = 0; i < 4; i++)
		begin
			// fresh carry-in at each lane boundary
			if (lane_start(i, size))
			begin
				carry = sub;
			end
			sum = {1'b0, a[8*i +: 8]} + {1'b0, b_eff[8*i +: 8]} + {8'd0, carry};
			y[8*i +: 8] = sum[7:0];
			// ripple into the next byte of the same lane
			carry = sum[8];
		end
	end

endmodule

// File: hdl/mem_bus_guard.sv
`timescale 1ns/1ps

module mem_bus_guard
	import lar_bus_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input mem_access_t acc,
	output mem_result_t res,
	output bus_req_t bus_req,
	input bus_rsp_t bus_rsp
);

	typedef enum logic [1:0]
	{
		st_idle,
		st_wait_hi,
		st_wait_lo,
		st_done
	} state_t;

	state_t state;
	logic req_q;
	// request fields, latched on start
	logic we_q;
	logic [15:0] addr_q;
	logic [31:0] wdata_q;
	// read data, captured on the ack rise
	logic [31:0] rdata_q;

	// four-phase handshake sequencer
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= st_idle;
			req_q <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle:
					if (acc.start)
					begin
						// req rises the cycle after start
						req_q <= 1'b1;
						state <= st_wait_hi;
					end
				st_wait_hi:
					if (bus_rsp.ack)
					begin
						req_q <= 1'b0;
						state <= st_wait_lo;
					end
				st_wait_lo:
					// memory has to drop ack before the next req
					if (!bus_rsp.ack)
						state <= st_done;
				default:
					state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == st_idle && acc.start)
		begin
			we_q <= acc.we;
			addr_q <= acc.addr;
			wdata_q <= acc.wdata;
		end
		if (state == st_wait_hi && bus_rsp.ack)
			rdata_q <= bus_rsp.rdata;
	end

	assign bus_req = '{req: req_q, we: we_q, addr: addr_q, wdata: wdata_q};
	// done is a single cycle pulse after ack fell
	assign res = '{done: (state == st_done), rdata: rdata_q};

	// controller must wait for done before the next start
	a_start_idle: assert property (
		@(posedge clk) disable iff (!arst_n)
		acc.start |-> (state == st_idle)
	)
	else
		$error("access started while the bus guard was busy");

	// a new req only once memory has let ack go low
	a_req_after_ack_low: assert property (
		@(posedge clk) disable iff (!arst_n)
		$rose(bus_req.req) |-> !$past(bus_rsp.ack)
	)
	else
		$error("bus req rose while ack was still high");

endmodule

// File: hdl/lar_ctrl.sv
`timescale 1ns/1ps

module lar_ctrl
	import lar_isa_pkg::*;
	import lar_bus_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input lar_rd_t rd_a,
	input lar_rd_t rd_b,
	input lar_rd_t rd_c,
	input mem_result_t res,
	output logic [1:0] rd_idx_a,
	output logic [1:0] rd_idx_b,
	output logic [1:0] rd_idx_c,
	output lar_wr_t wr,
	output mem_access_t acc,
	output logic halted
);

	typedef enum logic [2:0]
	{
		s_fetch,
		s_decode,
		s_exec,
		s_mem,
		s_wb,
		s_halted
	} state_t;

	state_t state;
	logic [15:0] pc;
	// set once the current access has been handed to the guard
	logic issued;
	instr_t ir;
	logic [31:0] alu_y;
	lane_size_t ld_size;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= s_fetch;
			pc <= reset_pc;
			issued <= 1'b0;
		end
		else
		begin
			if (acc.start)
				issued <= 1'b1;
			else if (res.done)
				issued <= 1'b0;
			case (state)
				s_fetch:
					if (res.done)
					begin
						pc <= pc + 16'd1;
						state <= s_decode;
					end
				s_decode:
					case (ir.opcode)
						op_ldw, op_stw:
							state <= s_mem;
						op_seta, op_add, op_sub:
							state <= s_exec;
						op_halt:
							state <= s_halted;
						// unknown opcodes retire as no-ops
						default:
							state <= s_fetch;
					endcase
				s_exec:
					state <= s_fetch;
				s_mem:
					if (res.done)
						state <= (ir.opcode == op_ldw) ? s_wb : s_fetch;
				s_wb:
					state <= s_fetch;
				// halt is final, only reset leaves it
				default:
					state <= s_halted;
			endcase
		end
	end

	// instruction register, loaded when the fetch completes
	always_ff @(posedge clk)
	begin
		if (state == s_fetch && res.done)
			ir <= instr_t'(res.rdata);
	end

	assign rd_idx_a = ir.ra;
	assign rd_idx_b = ir.rb;
	assign rd_idx_c = ir.rc;

	// rb op rc, lane width taken from rb
	lane_alu alu_i (
		.a(rd_b.data),
		.b(rd_c.data),
		.size(rd_b.meta.size),
		.sub(ir.opcode == op_sub),
		.y(alu_y)
	);

	// size code 3 folded into sz32
	assign ld_size = (ir.size == sz8 || ir.size == sz16) ? ir.size : sz32;

	// one access per fetch or memory state
	always_comb
	begin
		acc = '0;
		acc.start = (state == s_fetch || state == s_mem) && !issued;
		if (state == s_fetch)
			acc.addr = pc;
		else if (ir.opcode == op_stw)
		begin
			// store goes to the address ra carries
			acc.we = 1'b1;
			acc.addr = rd_a.meta.addr;
			acc.wdata = rd_a.data;
		end
		else
			acc.addr = ir.imm;
	end

	always_comb
	begin
		// add and sub by default, result takes rb's metadata
		wr.en = 1'b0;
		wr.idx = ir.ra;
		wr.meta = rd_b.meta;
		wr.data = alu_y;
		if (state == s_exec)
		begin
			wr.en = 1'b1;
			if (ir.opcode == op_seta)
			begin
				wr.meta = '{addr: ir.imm, size: rd_a.meta.size};
				wr.data = rd_a.data;
			end
		end
		else if (state == s_wb)
		begin
			// load data still held by the guard
			wr.en = 1'b1;
			wr.meta = '{addr: ir.imm, size: ld_size};
			wr.data = res.rdata;
		end
	end

	assign halted = (state == s_halted);

endmodule

// File: hdl/lar_cpu.sv
`timescale 1ns/1ps

module lar_cpu
	import lar_isa_pkg::*;
	import lar_bus_pkg::*;
(
	input logic clk,
	input logic arst_n,
	output bus_req_t bus_req,
	input bus_rsp_t bus_rsp,
	output logic halted
);

	// LAR file read and write ports
	logic [1:0] rd_idx_a;
	logic [1:0] rd_idx_b;
	logic [1:0] rd_idx_c;
	lar_rd_t rd_a;
	lar_rd_t rd_b;
	lar_rd_t rd_c;
	lar_wr_t wr;

	// controller to bus guard
	mem_access_t acc;
	mem_result_t res;

	// sequencer, also owns the ALU
	lar_ctrl ctrl_i (
		.clk(clk),
		.arst_n(arst_n),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.rd_c(rd_c),
		.res(res),
		.rd_idx_a(rd_idx_a),
		.rd_idx_b(rd_idx_b),
		.rd_idx_c(rd_idx_c),
		.wr(wr),
		.acc(acc),
		.halted(halted)
	);

	lar_file lar_file_i (
		.clk(clk),
		.arst_n(arst_n),
		.rd_idx_a(rd_idx_a),
		.rd_idx_b(rd_idx_b),
		.rd_idx_c(rd_idx_c),
		.wr(wr),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.rd_c(rd_c)
	);

	// sole owner of the external bus
	mem_bus_guard guard_i (
		.clk(clk),
		.arst_n(arst_n),
		.acc(acc),
		.res(res),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp)
	);

endmodule

// File: verif/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model
	import lar_bus_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input bus_req_t bus_req,
	output bus_rsp_t bus_rsp,
	output logic stuck
);

	// word memory, loaded by the testbench top before reset ends
	logic [31:0] mem [1024];
	integer delay_seed;
	int waited;

	// 0 to 5 falling edges of latency
	task automatic pause_random();
		int n;
		n = $unsigned($random(delay_seed)) % 6;
		repeat (n) @(negedge clk);
	endtask

	// four-phase responder, all outputs change on falling edges
	initial
	begin
		delay_seed = 80361;
		bus_rsp = '0;
		stuck = 1'b0;
		waited = 0;
		forever
		begin
			@(negedge clk);
			if (arst_n && bus_req.req && !bus_rsp.ack)
			begin
				pause_random();
				// write lands when ack rises
				if (bus_req.we)
					mem[bus_req.addr[9:0]] = bus_req.wdata;
				bus_rsp.rdata = mem[bus_req.addr[9:0]];
				bus_rsp.ack = 1'b1;
				// hold ack until req falls
				waited = 0;
				while (bus_req.req && waited < 1000)
				begin
					@(negedge clk);
					waited++;
				end
				if (bus_req.req)
					stuck = 1'b1;
				pause_random();
				bus_rsp.ack = 1'b0;
			end
		end
	end

endmodule

// File: verif/tb_lar_cpu.sv
`timescale 1ns/1ps

module tb_lar_cpu
	import lar_isa_pkg::*;
	import lar_bus_pkg::*;
();

	localparam int prog_len = 40;
	localparam int mem_words = 1024;
	localparam int t_reset = 0;
	localparam int t_fetch = 1;
	localparam int t_store = 2;
	localparam int t_hs = 3;
	localparam int t_halt = 4;
	localparam int t_count = 5;

	logic clk;
	logic arst_n;
	bus_req_t bus_req;
	bus_rsp_t bus_rsp;
	logic halted;
	logic mem_stuck;
	integer seed;

	// reference model state
	logic [15:0] m_addr [4];
	logic [1:0] m_size [4];
	logic [31:0] m_data [4];
	logic [31:0] exp_mem [mem_words];
	logic [15:0] st_addr_q [$];
	logic [31:0] st_data_q [$];
	int st_expected;

	// bus monitor state
	bus_req_t prev_req;
	logic prev_ack;
	logic [15:0] fetch_pc;
	int req_rises;
	int st_seen;
	int errs [6];

	lar_cpu dut_i (
		.clk(clk),
		.arst_n(arst_n),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp),
		.halted(halted)
	);

	tb_mem_model mem_i (
		.clk(clk),
		.arst_n(arst_n),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp),
		.stuck(mem_stuck)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] encode(input logic [3:0] op, input logic [1:0] ra,
		input logic [1:0] rb, input logic [1:0] rc, input logic [1:0] sz, input logic [15:0] imm);
		return {op, ra, rb, rc, sz, 4'd0, imm};
	endfunction

	// background word, unique per address
	function automatic logic [31:0] fill_word(input int i);
		return {~i[15:0], i[15:0]};
	endfunction

	// each lane wraps modulo its own width
	function automatic logic [31:0] lane_op(input logic [31:0] a, input logic [31:0] b,
		input logic [1:0] sz, input logic sub);
		logic [31:0] y;
		logic [31:0] la;
		logic [31:0] lb;
		logic [31:0] r;
		logic [31:0] mask;
		int w;
		y = 32'd0;
		w = (sz == 2'd0) ? 8 : (sz == 2'd1) ? 16 : 32;
		mask = (w == 32) ? 32'hffffffff : ((32'd1 << w) - 32'd1);
		for (int lo = 0; lo < 32; lo += w)
		begin
			la = a >> lo;
			lb = b >> lo;
			r = sub ? la - lb : la + lb;
			y = y | ((r & mask) << lo);
		end
		return y;
	endfunction

	// one instruction on the model LARs
	task automatic run_model(input logic [31:0] w);
		logic [3:0] op;
		logic [1:0] ra;
		logic [1:0] rb;
		logic [1:0] rc;
		logic [1:0] sz;
		logic [15:0] imm;
		logic [31:0] y;
		op = w[31:28];
		ra = w[27:26];
		rb = w[25:24];
		rc = w[23:22];
		sz = w[21:20];
		imm = w[15:0];
		case (op)
			op_ldw:
			begin
				m_data[ra] = exp_mem[imm[9:0]];
				m_addr[ra] = imm;
				m_size[ra] = (sz == 2'd3) ? 2'd2 : sz;
			end
			op_stw:
			begin
				exp_mem[m_addr[ra][9:0]] = m_data[ra];
				st_addr_q.push_back(m_addr[ra]);
				st_data_q.push_back(m_data[ra]);
				st_expected++;
			end
			op_seta:
				m_addr[ra] = imm;
			op_add, op_sub:
			begin
				// rb and rc read before ra is written
				y = lane_op(m_data[rb], m_data[rc], m_size[rb], op == op_sub);
				m_addr[ra] = m_addr[rb];
				m_size[ra] = m_size[rb];
				m_data[ra] = y;
			end
			default:
				y = 32'd0;
		endcase
	endtask

	// program at word 0, data at 0x100, stores aimed at 0x200 and up
	task automatic build_program();
		logic [31:0] r;
		logic [31:0] w;
		logic [1:0] st_reg;
		st_reg = 2'd0;
		for (int i = 0; i < mem_words; i++)
		begin
			w = fill_word(i);
			mem_i.mem[i] = w;
			exp_mem[i] = w;
		end
		for (int i = 0; i < 32; i++)
		begin
			w = $random(seed);
			mem_i.mem[256 + i] = w;
			exp_mem[256 + i] = w;
		end
		for (int i = 0; i < prog_len - 1; i++)
		begin
			r = $random(seed);
			if (i % 6 == 5)
				w = encode(op_stw, st_reg, 2'd0, 2'd0, 2'd0, 16'd0);
			else if (i % 6 == 4 || r[9:8] == 2'd1)
			begin
				// seta just before a store picks the LAR to store
				if (i % 6 == 4)
					st_reg = r[1:0];
				w = encode(op_seta, r[1:0], r[3:2], r[5:4], r[7:6], 16'h0200 + {8'd0, r[23:16]});
			end
			else if (r[9:8] == 2'd0)
				w = encode(op_ldw, r[1:0], r[3:2], r[5:4], r[7:6], 16'h0100 + {11'd0, r[20:16]});
			else
				w = encode(r[8] ? op_sub : op_add, r[1:0], r[3:2], r[5:4], r[7:6], 16'd0);
			mem_i.mem[i] = w;
			exp_mem[i] = w;
			run_model(w);
		end
		w = encode(op_halt, 2'd0, 2'd0, 2'd0, 2'd0, 16'd0);
		mem_i.mem[prog_len - 1] = w;
		exp_mem[prog_len - 1] = w;
	endtask

	task automatic report_test(input int idx, input string name);
		$display("test %0d, %s: %s with %0d errors", idx + 1, name,
			(errs[idx] == 0) ? "ok" : "not ok", errs[idx]);
	endtask

	// sampled at rising edges, values settled since the last falling edge
	always @(posedge clk)
	begin
		if (!arst_n)
		begin
			assert (!bus_req.req && !halted)
			else
			begin
				$display("Fail %0t: req or halted high during reset", $time);
				errs[t_reset]++;
			end
			prev_req = '0;
			prev_ack = 1'b0;
		end
		else
		begin
			if (bus_req.req && !prev_req.req)
			begin
				req_rises++;
				assert (!prev_ack)
				else
				begin
					$display("Fail %0t: req rose while ack was high", $time);
					errs[t_hs]++;
				end
				if (bus_req.we)
				begin
					st_seen++;
					assert (st_addr_q.size() > 0)
					else
					begin
						$display("Fail %0t: store to %h beyond the model's stores", $time,
							bus_req.addr);
						errs[t_store]++;
					end
					if (st_addr_q.size() > 0)
					begin
						assert (bus_req.addr == st_addr_q[0] && bus_req.wdata == st_data_q[0])
						else
						begin
							$display("Fail %0t: store %h <- %h, expected %h <- %h", $time,
								bus_req.addr, bus_req.wdata, st_addr_q[0], st_data_q[0]);
							errs[t_store]++;
						end
						void'(st_addr_q.pop_front());
						void'(st_data_q.pop_front());
					end
				end
				else if (bus_req.addr < 16'h0100)
				begin
					// fetches walk up one word at a time
					assert (bus_req.addr == fetch_pc)
					else
					begin
						$display("Fail %0t: fetch at %h, expected %h", $time, bus_req.addr,
							fetch_pc);
						errs[t_fetch]++;
					end
					fetch_pc = bus_req.addr + 16'd1;
				end
			end
			if (bus_req.req && prev_req.req)
			begin
				assert ({bus_req.we, bus_req.addr, bus_req.wdata} ==
					{prev_req.we, prev_req.addr, prev_req.wdata})
				else
				begin
					$display("Fail %0t: request fields moved while req was high", $time);
					errs[t_hs]++;
				end
			end
			prev_req = bus_req;
			prev_ack = bus_rsp.ack;
		end
	end

	initial
	begin
		int cycles;
		int rises_at_halt;
		int bad_words;
		int failed;
		clk = 1'b0;
		arst_n = 1'b0;
		seed = 80361;
		fetch_pc = reset_pc;
		req_rises = 0;
		st_seen = 0;
		st_expected = 0;
		failed = 0;
		for (int i = 0; i < 6; i++)
			errs[i] = 0;
		// reset contents of every LAR
		for (int i = 0; i < 4; i++)
		begin
			m_addr[i] = 16'd0;
			m_size[i] = 2'd2;
			m_data[i] = 32'd0;
		end
		build_program();
		repeat (10) @(negedge clk);
		arst_n = 1'b1;
		@(posedge clk);
		assert (!bus_req.req && !halted)
		else
		begin
			$display("Fail %0t: req or halted high right after reset", $time);
			errs[t_reset]++;
		end
		report_test(t_reset, "reset state");
		cycles = 0;
		while (!halted && cycles < 20000)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!halted)
		begin
			$display("halted never rose within %0d cycles, the core is stuck", cycles);
			$display("Testbench failed");
			$finish;
		end
		else
		begin
			// halt has to be the last word fetched
			assert (fetch_pc == 16'(prog_len))
			else
			begin
				$display("Fail %0t: halted with next fetch at %h", $time, fetch_pc);
				errs[t_halt]++;
			end
			rises_at_halt = req_rises;
			repeat (50) @(negedge clk);
			assert (req_rises == rises_at_halt && halted)
			else
			begin
				$display("Fail %0t: bus activity or halted drop after halt", $time);
				errs[t_halt]++;
			end
			assert (!mem_stuck)
			else
			begin
				$display("memory gave up waiting for req to fall");
				errs[t_hs]++;
			end
			bad_words = 0;
			for (int i = 0; i < mem_words; i++)
			begin
				assert (mem_i.mem[i] == exp_mem[i])
				else
				begin
					$display("Fail %0t: word %h is %h, expected %h", $time, i[15:0],
						mem_i.mem[i], exp_mem[i]);
					bad_words++;
				end
			end
			errs[t_count] += bad_words;
			assert (st_seen == st_expected)
			else
			begin
				$display("Fail %0t: %0d stores seen, expected %0d", $time, st_seen, st_expected);
				errs[t_count]++;
			end
			report_test(t_fetch, "fetch order");
			report_test(t_store, "stores");
			report_test(t_hs, "handshake");
			report_test(t_halt, "halt");
			report_test(t_count, "store count and image");
			for (int i = 0; i < 6; i++)
				if (errs[i] != 0)
					failed++;
			$display("%0d tests, %0d ok, %0d not ok", 6, 6 - failed, failed);
			if (failed == 0)
				$display("Testbench passed");
			else
				$display("Testbench failed");
			$finish;
		end
	end

endmodule

// File: lar_cpu.f
hdl/lar_isa_pkg.sv
hdl/lar_bus_pkg.sv
hdl/lar_file.sv
hdl/lane_alu.sv
hdl/mem_bus_guard.sv
hdl/lar_ctrl.sv
hdl/lar_cpu.sv
verif/tb_mem_model.sv
verif/tb_lar_cpu.sv

// File: Makefile
# Verilator flow for the lar_cpu testbench
TOP = tb_lar_cpu

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f lar_cpu.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee run.log
	@if grep -q "Testbench failed" run.log; then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Testbench passed" run.log; then echo "simulation ended early"; exit 1; fi

lint:
	verilator --lint-only --timing -Wall -f lar_cpu.f --top-module $(TOP)

clean:
	rm -rf obj_dir run.log
